// ==== hdl/bpu_pkg.sv ====
package bpu_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [1:0]  wb_adr_t;

    localparam int TAG_BITS = 30;             // pc[31:2]
    localparam addr_t FETCH_BYTES = 32'd8;    // two slots per packet

    // update register map
    localparam wb_adr_t UPD_ADR_PC   = 2'd0;
    localparam wb_adr_t UPD_ADR_DEST = 2'd1;
    localparam wb_adr_t UPD_ADR_CTRL = 2'd2;  // write commits the report

    localparam int CTRL_TAKEN_BIT = 0;
    localparam int CTRL_JUMP_BIT  = 1;

endpackage

// ==== hdl/lutram_dp.sv ====
`timescale 1ns/1ns

module lutram_dp #(
    parameter int ADDR_BITS = 4,
    parameter int STRB_BITS = 1,
    parameter type word_t = logic [31:0]
) (
    input  logic                 clk,
    input  logic [ADDR_BITS-1:0] rd_addr,
    output word_t                rd_data,
    input  logic                 rw_en,
    input  logic [ADDR_BITS-1:0] rw_addr,
    input  logic [STRB_BITS-1:0] rw_strb,
    input  word_t                rw_wdata,
    output word_t                rw_rdata
);
    localparam int WORD_BITS = $bits(word_t);
    localparam int LANE_BITS = WORD_BITS / STRB_BITS;
    localparam int DEPTH     = 2 ** ADDR_BITS;

    logic [WORD_BITS-1:0] mem [DEPTH];
    logic [WORD_BITS-1:0] wdata_bits;

    assign wdata_bits = rw_wdata;

    // both ports read asynchronously
    assign rd_data  = word_t'(mem[rd_addr]);
    assign rw_rdata = word_t'(mem[rw_addr]);

    always_ff @(posedge clk) begin
        if (rw_en) begin
            for (int i = 0; i < STRB_BITS; i++) begin
                if (rw_strb[i]) begin
                    mem[rw_addr][i*LANE_BITS +: LANE_BITS] <=
                        wdata_bits[i*LANE_BITS +: LANE_BITS];   // lane write
                end
            end
        end
    end

endmodule

// ==== hdl/plru_tree.sv ====
`timescale 1ns/1ns

module plru_tree #(
    parameter int ASSOCIATIVITY = 2,
    parameter int SET_NUM       = 16,
    localparam int INDEX_BITS   = $clog2(SET_NUM),
    localparam int WAY_BITS     = $clog2(ASSOCIATIVITY)
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  touch_en,
    input  logic [INDEX_BITS-1:0] touch_set,
    input  logic [WAY_BITS-1:0]   touch_way,
    input  logic [INDEX_BITS-1:0] victim_set,
    output logic [WAY_BITS-1:0]   victim_way
);
    localparam int NODES = ASSOCIATIVITY - 1;

    logic [NODES-1:0] tree [SET_NUM];
    logic [NODES-1:0] touched;

    // point each node on the path away from way
    function automatic logic [NODES-1:0] touch_bits(input logic [NODES-1:0] cur,
                                                    input logic [WAY_BITS-1:0] way);
        logic [NODES-1:0] nxt;
        int               node;
        logic             dir;
        nxt  = cur;
        node = 0;
        for (int l = 0; l < WAY_BITS; l++) begin
            dir       = way[WAY_BITS-1-l];
            nxt[node] = ~dir;
            node      = 2 * node + 1 + int'(dir);   // heap order
        end
        return nxt;
    endfunction

    function automatic logic [WAY_BITS-1:0] find_victim(input logic [NODES-1:0] cur);
        logic [WAY_BITS-1:0] way;
        int                  node;
        way  = '0;
        node = 0;
        for (int l = 0; l < WAY_BITS; l++) begin
            way[WAY_BITS-1-l] = cur[node];   // 0 goes left
            node              = 2 * node + 1 + int'(cur[node]);
        end
        return way;
    endfunction

    assign touched    = touch_bits(tree[touch_set], touch_way);
    assign victim_way = find_victim(tree[victim_set]);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SET_NUM; s++) begin
                tree[s] <= '0;
            end
        end else if (touch_en) begin
            tree[touch_set] <= touched;
        end
    end

    a_touch_way_known: assert property (@(posedge clk) disable iff (rst)
        touch_en |-> !$isunknown(touch_way));

endmodule

// ==== hdl/bht_update_wb.sv ====
`timescale 1ns/1ns

module bht_update_wb (
    input  logic              clk,
    input  logic              rst,
    input  logic              ready,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  bpu_pkg::wb_adr_t  wb_adr,
    input  bpu_pkg::wb_data_t wb_dat_w,
    output bpu_pkg::wb_data_t wb_dat_r,
    output logic              wb_ack,
    output logic              upd_valid,
    output bpu_pkg::addr_t    upd_pc,
    output bpu_pkg::addr_t    upd_dest,
    output logic              upd_taken,
    output logic              upd_jump
);
    import bpu_pkg::*;

    addr_t    pc_q;
    addr_t    dest_q;
    wb_data_t ctrl_q;
    logic     accept;

    // held off while the table is sweeping
    assign accept = wb_cyc & wb_stb & ready & ~wb_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack    <= 1'b0;
            upd_valid <= 1'b0;
        end else begin
            wb_ack    <= accept;
            upd_valid <= accept & wb_we & (wb_adr == UPD_ADR_CTRL);   // lines up with ack
        end
    end

    always_ff @(posedge clk) begin
        if (accept && wb_we) begin
            case (wb_adr)
                UPD_ADR_PC:   pc_q   <= wb_dat_w;
                UPD_ADR_DEST: dest_q <= wb_dat_w;
                UPD_ADR_CTRL: ctrl_q <= wb_dat_w;
                default:      ctrl_q <= ctrl_q;
            endcase
        end
        if (accept) begin
            case (wb_adr)
                UPD_ADR_PC:   wb_dat_r <= pc_q;
                UPD_ADR_DEST: wb_dat_r <= dest_q;
                UPD_ADR_CTRL: wb_dat_r <= ctrl_q;
                default:      wb_dat_r <= '0;
            endcase
        end
    end

    assign upd_pc    = pc_q;
    assign upd_dest  = dest_q;
    assign upd_taken = ctrl_q[CTRL_TAKEN_BIT];
    assign upd_jump  = ctrl_q[CTRL_JUMP_BIT];

    a_single_ack: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack);

endmodule

// ==== hdl/bht.sv ====
`timescale 1ns/1ns

module bht #(
    parameter int ASSOCIATIVITY = 2,
    parameter int SET_NUM       = 16,
    parameter int BH_BITS       = 2
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           fetch_valid,
    input  bpu_pkg::addr_t fetch_pc,
    input  logic           upd_valid,
    input  bpu_pkg::addr_t upd_pc,
    input  bpu_pkg::addr_t upd_dest,
    input  logic           upd_taken,
    input  logic           upd_jump,
    output logic           ready,
    output logic           hit,
    output logic           hit_slot,
    output logic           is_jump,
    output logic           dir_taken,
    output bpu_pkg::addr_t target
);
    import bpu_pkg::*;

    localparam int COUNTER_BITS = 2;
    localparam int INDEX_BITS   = $clog2(SET_NUM);
    localparam int WAY_BITS     = $clog2(ASSOCIATIVITY);
    localparam int LINE_BITS    = INDEX_BITS + WAY_BITS;
    localparam int HIST_ENTRIES = 2 ** BH_BITS;

    typedef logic [TAG_BITS-1:0]     tag_t;
    typedef logic [INDEX_BITS-1:0]   index_t;
    typedef logic [WAY_BITS-1:0]     way_t;
    typedef logic [LINE_BITS-1:0]    line_addr_t;
    typedef logic [BH_BITS-1:0]      bhr_t;
    typedef logic [COUNTER_BITS-1:0] counter_t;

    typedef struct packed {
        logic valid;
        logic is_jump;
        tag_t tag;
    } meta_t;

    typedef meta_t [ASSOCIATIVITY-1:0] meta_set_t;

    typedef struct packed {
        addr_t target;
        bhr_t  bhr;
    } line_t;

    typedef counter_t [HIST_ENTRIES-1:0] counters_t;

    index_t     fetch_set, upd_set, meta_addr;
    tag_t       tag_slot0, tag_slot1, upd_tag;
    addr_t      pc_plus4;
    meta_set_t  pred_meta, upd_meta, meta_wdata;
    line_t      pred_line, upd_line, line_wdata;
    counters_t  pred_cnt, upd_cnt, cnt_wdata;
    logic       hit0, hit1, jump0, jump1, upd_hit;
    way_t       way0, way1, hit_way, upd_hit_way, victim_way, upd_way;
    counter_t   old_cnt, new_cnt;
    logic [ASSOCIATIVITY-1:0] meta_strb;
    logic [HIST_ENTRIES-1:0]  cnt_strb;
    logic       meta_en, line_en;
    line_addr_t line_addr;
    logic       init_busy;
    line_addr_t init_cnt;

    assign fetch_set = fetch_pc[3 +: INDEX_BITS];
    assign pc_plus4  = fetch_pc + 32'd4;
    assign tag_slot0 = fetch_pc[31:2];
    assign tag_slot1 = pc_plus4[31:2];

    always_comb begin
        hit0  = 1'b0;
        hit1  = 1'b0;
        way0  = '0;
        way1  = '0;
        jump0 = 1'b0;
        jump1 = 1'b0;
        for (int w = 0; w < ASSOCIATIVITY; w++) begin
            if (pred_meta[w].valid && pred_meta[w].tag == tag_slot0) begin
                hit0  = 1'b1;
                way0  = way_t'(w);
                jump0 = pred_meta[w].is_jump;
            end
            if (pred_meta[w].valid && pred_meta[w].tag == tag_slot1) begin
                hit1  = 1'b1;
                way1  = way_t'(w);
                jump1 = pred_meta[w].is_jump;
            end
        end
    end

    // slot 0 wins when both hit
    assign hit       = ready & (hit0 | hit1);
    assign hit_slot  = ~hit0 & hit1;
    assign hit_way   = hit0 ? way0 : way1;
    assign is_jump   = hit0 ? jump0 : jump1;
    assign target    = pred_line.target;
    assign dir_taken = pred_cnt[pred_line.bhr][COUNTER_BITS-1];

    assign upd_set = upd_pc[3 +: INDEX_BITS];
    assign upd_tag = upd_pc[31:2];

    always_comb begin
        upd_hit     = 1'b0;
        upd_hit_way = '0;
        for (int w = 0; w < ASSOCIATIVITY; w++) begin
            if (upd_meta[w].valid && upd_meta[w].tag == upd_tag) begin
                upd_hit     = 1'b1;
                upd_hit_way = way_t'(w);
            end
        end
    end

    assign upd_way = upd_hit ? upd_hit_way : victim_way;
    assign old_cnt = upd_cnt[upd_line.bhr];

    // two-bit saturating step
    always_comb begin
        if (upd_taken) begin
            new_cnt = (old_cnt == '1) ? old_cnt : old_cnt + 1'b1;
        end else begin
            new_cnt = (old_cnt == '0) ? old_cnt : old_cnt - 1'b1;
        end
    end

    always_comb begin
        meta_addr = upd_set;
        line_addr = {upd_set, upd_way};
        meta_en   = upd_valid & ~upd_hit;   // install only
        line_en   = upd_valid;
        meta_strb = ASSOCIATIVITY'(1) << victim_way;
        cnt_strb  = upd_hit ? (HIST_ENTRIES'(1) << upd_line.bhr) : '1;
        for (int w = 0; w < ASSOCIATIVITY; w++) begin
            meta_wdata[w] = '{valid: 1'b1, is_jump: upd_jump, tag: upd_tag};
        end
        line_wdata.target = upd_hit ? upd_line.target : upd_dest;
        line_wdata.bhr    = upd_hit ? bhr_t'({upd_line.bhr, upd_taken}) : '0;
        cnt_wdata         = upd_hit ? {HIST_ENTRIES{new_cnt}} : '1;
        if (init_busy) begin
            meta_addr  = init_cnt[WAY_BITS +: INDEX_BITS];
            line_addr  = init_cnt;
            meta_en    = 1'b1;
            line_en    = 1'b1;
            meta_strb  = ASSOCIATIVITY'(1) << init_cnt[WAY_BITS-1:0];
            cnt_strb   = '1;
            meta_wdata = '0;
            line_wdata = '0;
            cnt_wdata  = '1;   // strongly taken start
        end
    end

    // one entry per cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            init_busy <= 1'b1;
            init_cnt  <= '0;
        end else if (init_busy) begin
            init_cnt <= init_cnt + 1'b1;
            if (init_cnt == '1) begin
                init_busy <= 1'b0;
            end
        end
    end

    assign ready = ~init_busy;

    lutram_dp #(
        .ADDR_BITS(INDEX_BITS),
        .STRB_BITS(ASSOCIATIVITY),
        .word_t   (meta_set_t)
    ) u_meta_ram (
        .clk     (clk),
        .rd_addr (fetch_set),
        .rd_data (pred_meta),
        .rw_en   (meta_en),
        .rw_addr (meta_addr),
        .rw_strb (meta_strb),
        .rw_wdata(meta_wdata),
        .rw_rdata(upd_meta)
    );

    lutram_dp #(
        .ADDR_BITS(LINE_BITS),
        .STRB_BITS(1),
        .word_t   (line_t)
    ) u_line_ram (
        .clk     (clk),
        .rd_addr ({fetch_set, hit_way}),
        .rd_data (pred_line),
        .rw_en   (line_en),
        .rw_addr (line_addr),
        .rw_strb (1'b1),
        .rw_wdata(line_wdata),
        .rw_rdata(upd_line)
    );

    lutram_dp #(
        .ADDR_BITS(LINE_BITS),
        .STRB_BITS(HIST_ENTRIES),
        .word_t   (counters_t)
    ) u_counter_ram (
        .clk     (clk),
        .rd_addr ({fetch_set, hit_way}),
        .rd_data (pred_cnt),
        .rw_en   (line_en),
        .rw_addr (line_addr),
        .rw_strb (cnt_strb),
        .rw_wdata(cnt_wdata),
        .rw_rdata(upd_cnt)
    );

    plru_tree #(
        .ASSOCIATIVITY(ASSOCIATIVITY),
        .SET_NUM      (SET_NUM)
    ) u_plru (
        .clk       (clk),
        .rst       (rst),
        .touch_en  (hit & fetch_valid),
        .touch_set (fetch_set),
        .touch_way (hit_way),
        .victim_set(upd_set),
        .victim_way(victim_way)
    );

    a_no_update_in_init: assert property (@(posedge clk) disable iff (rst)
        upd_valid |-> ready);

endmodule

// ==== hdl/next_pc_select.sv ====
`timescale 1ns/1ns

module next_pc_select (
    input  logic           clk,
    input  logic           rst,
    input  logic           fetch_valid,
    input  bpu_pkg::addr_t fetch_pc,
    input  logic           hit,
    input  logic           hit_slot,
    input  logic           is_jump,
    input  logic           dir_taken,
    input  bpu_pkg::addr_t target,
    output logic           pred_valid,
    output logic           pred_taken,
    output logic           pred_slot,
    output bpu_pkg::addr_t pred_next_pc
);
    import bpu_pkg::*;

    logic  taken;
    addr_t next_pc;

    assign taken   = hit & (is_jump | dir_taken);
    assign next_pc = taken ? target : fetch_pc + FETCH_BYTES;   // fall through a packet

    always_ff @(posedge clk) begin
        if (rst) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        pred_taken   <= taken;
        pred_slot    <= hit_slot;
        pred_next_pc <= next_pc;
    end

endmodule

// ==== hdl/bpu_top.sv ====
`timescale 1ns/1ns

module bpu_top #(
    parameter int ASSOCIATIVITY = 2,
    parameter int SET_NUM       = 16,
    parameter int BH_BITS       = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              fetch_valid,
    input  bpu_pkg::addr_t    fetch_pc,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  bpu_pkg::wb_adr_t  wb_adr,
    input  bpu_pkg::wb_data_t wb_dat_w,
    output bpu_pkg::wb_data_t wb_dat_r,
    output logic              wb_ack,
    output logic              bpu_ready,
    output logic              pred_valid,
    output logic              pred_taken,
    output logic              pred_slot,
    output bpu_pkg::addr_t    pred_next_pc
);
    import bpu_pkg::*;

    logic  upd_valid, upd_taken, upd_jump;
    addr_t upd_pc, upd_dest;
    logic  hit, hit_slot, is_jump, dir_taken;
    addr_t target;

    bht_update_wb u_update (
        .clk      (clk),
        .rst      (rst),
        .ready    (bpu_ready),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .upd_valid(upd_valid),
        .upd_pc   (upd_pc),
        .upd_dest (upd_dest),
        .upd_taken(upd_taken),
        .upd_jump (upd_jump)
    );

    bht #(
        .ASSOCIATIVITY(ASSOCIATIVITY),
        .SET_NUM      (SET_NUM),
        .BH_BITS      (BH_BITS)
    ) u_bht (
        .clk        (clk),
        .rst        (rst),
        .fetch_valid(fetch_valid),
        .fetch_pc   (fetch_pc),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_dest   (upd_dest),
        .upd_taken  (upd_taken),
        .upd_jump   (upd_jump),
        .ready      (bpu_ready),
        .hit        (hit),
        .hit_slot   (hit_slot),
        .is_jump    (is_jump),
        .dir_taken  (dir_taken),
        .target     (target)
    );

    next_pc_select u_next_pc (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .hit         (hit),
        .hit_slot    (hit_slot),
        .is_jump     (is_jump),
        .dir_taken   (dir_taken),
        .target      (target),
        .pred_valid  (pred_valid),
        .pred_taken  (pred_taken),
        .pred_slot   (pred_slot),
        .pred_next_pc(pred_next_pc)
    );

endmodule

// ==== tb/bpu_tests.svh ====
task automatic wb_cycle(input logic we, input wb_adr_t adr, input wb_data_t wdata,
                        output wb_data_t rdata);
    int waited;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    waited = 0;
    do begin
        @(negedge clk);
        waited++;
        if (waited > ACK_LIMIT) begin
            $display("no Wishbone ack within %0d cycles", ACK_LIMIT);
            stop_with_failure();
        end
    end while (!wb_ack);
    rdata = wb_dat_r;   // valid during ack
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
endtask

task automatic wb_write(input wb_adr_t adr, input wb_data_t data);
    wb_data_t ignored;
    wb_cycle(1'b1, adr, data, ignored);
endtask

task automatic wb_read(input wb_adr_t adr, input wb_data_t expected);
    wb_data_t rdata;
    wb_cycle(1'b0, adr, '0, rdata);
    check_data("wb_dat_r", rdata, expected);
endtask

// CTRL write commits one resolved branch
task automatic report_branch(input addr_t pc, input addr_t dest, input logic taken,
                             input logic jump);
    wb_data_t ctrl;
    ctrl = '0;
    ctrl[CTRL_TAKEN_BIT] = taken;
    ctrl[CTRL_JUMP_BIT]  = jump;
    wb_write(UPD_ADR_PC, pc);
    wb_write(UPD_ADR_DEST, dest);
    wb_write(UPD_ADR_CTRL, ctrl);
    apply_report(pc, dest, taken, jump);
endtask

task automatic fetch(input addr_t pc);
    logic  exp_slot;
    logic  exp_taken;
    addr_t exp_next;
    @(posedge clk);
    fetch_valid <= 1'b1;
    fetch_pc    <= pc;
    expect_prediction(pc, exp_slot, exp_taken, exp_next);
    @(posedge clk);
    fetch_valid <= 1'b0;
    @(negedge clk);
    check_bit("pred_valid", pred_valid, 1'b1);
    check_bit("pred_taken", pred_taken, exp_taken);
    check_bit("pred_slot", pred_slot, exp_slot);
    check_addr("pred_next_pc", pred_next_pc, exp_next);
    @(negedge clk);
    check_bit("pred_valid", pred_valid, 1'b0);   // fetch_valid already low
endtask

task automatic test_cold_table();
    addr_t pc;
    wb_write(UPD_ADR_PC, 32'h1234_5670);
    wb_write(UPD_ADR_DEST, 32'h89ab_cdef);
    wb_read(UPD_ADR_PC, 32'h1234_5670);
    wb_read(UPD_ADR_DEST, 32'h89ab_cdef);
    for (int i = 0; i < RANDOM_FETCHES; i++) begin
        pc = $urandom();
        pc[2:0] = 3'b000;   // packet aligned
        fetch(pc);
    end
endtask

task automatic test_install();
    report_branch(32'h0000_1004, 32'h0000_2000, 1'b1, 1'b0);   // slot 1 of packet 0x1000
    fetch(32'h0000_1000);
    report_branch(32'h0000_1010, 32'h0000_3000, 1'b1, 1'b0);
    fetch(32'h0000_1010);
    wb_read(UPD_ADR_CTRL, 32'h0000_0001);
endtask

task automatic test_train();
    logic [6:0] outcomes;
    outcomes = 7'b1101000;   // lsb first
    for (int i = 0; i < 7; i++) begin
        report_branch(32'h0000_1004, 32'h0000_2000, outcomes[i], 1'b0);
        fetch(32'h0000_1000);
    end
endtask

task automatic test_jump_priority();
    report_branch(32'h0000_1020, 32'h0000_4000, 1'b1, 1'b1);
    fetch(32'h0000_1020);
    repeat (3) begin
        report_branch(32'h0000_1020, 32'h0000_4000, 1'b0, 1'b1);
        fetch(32'h0000_1020);
    end
    report_branch(32'h0000_1024, 32'h0000_5000, 1'b1, 1'b0);   // slot 1 of the same packet
    fetch(32'h0000_1020);
endtask

task automatic test_eviction();
    addr_t base;
    addr_t step;
    base = 32'h0000_8030;   // set 6
    step = 32'h0000_0100;
    for (int i = 0; i < ASSOCIATIVITY; i++) begin
        report_branch(base + addr_t'(i) * step, 32'h0000_6000 + addr_t'(i) * 32'h10,
                      1'b1, 1'b0);
        fetch(base + addr_t'(i) * step);
    end
    fetch(base);
    report_branch(base + addr_t'(ASSOCIATIVITY) * step, 32'h0000_7000, 1'b1, 1'b0);
    for (int i = 0; i <= ASSOCIATIVITY; i++) begin
        fetch(base + addr_t'(i) * step);
    end
endtask

// ==== tb/bpu_tb.sv ====
`timescale 1ns/1ns

module bpu_tb;
    import bpu_pkg::*;

    localparam int ASSOCIATIVITY  = 2;
    localparam int SET_NUM        = 16;
    localparam int BH_BITS        = 2;
    localparam int NODES          = ASSOCIATIVITY - 1;
    localparam int HIST_ENTRIES   = 2 ** BH_BITS;
    localparam int SET_BITS       = $clog2(SET_NUM);
    localparam int RANDOM_FETCHES = 16;
    localparam int FETCH_COUNT    = RANDOM_FETCHES + 14 + 2 * ASSOCIATIVITY + 2;
    localparam int WB_COUNT       = 47 + 3 * (ASSOCIATIVITY + 1);   // three writes per report
    localparam int WATCHDOG_NS    = (FETCH_COUNT + 4 * WB_COUNT + 200) * 10;
    localparam int ACK_LIMIT      = 16;
    localparam int READY_LIMIT    = SET_NUM * ASSOCIATIVITY + 8;

    logic     clk;
    logic     rst;
    logic     fetch_valid;
    addr_t    fetch_pc;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_adr_t  wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;
    logic     bpu_ready;
    logic     pred_valid;
    logic     pred_taken;
    logic     pred_slot;
    addr_t    pred_next_pc;

    // reference copy of the table
    logic                ref_valid  [SET_NUM][ASSOCIATIVITY];
    logic                ref_jump   [SET_NUM][ASSOCIATIVITY];
    logic [TAG_BITS-1:0] ref_tag    [SET_NUM][ASSOCIATIVITY];
    addr_t               ref_target [SET_NUM][ASSOCIATIVITY];
    logic [BH_BITS-1:0]  ref_bhr    [SET_NUM][ASSOCIATIVITY];
    logic [1:0]          ref_cnt    [SET_NUM][ASSOCIATIVITY][HIST_ENTRIES];
    logic [NODES-1:0]    ref_tree   [SET_NUM];

    bpu_top #(
        .ASSOCIATIVITY(ASSOCIATIVITY),
        .SET_NUM      (SET_NUM),
        .BH_BITS      (BH_BITS)
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("** FAIL **");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_addr(input string name, input addr_t actual, input addr_t expected);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_data(input string name, input wb_data_t actual,
                              input wb_data_t expected);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t signal=%s expected=%b actual=%b",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic clear_ref_tables();
        for (int s = 0; s < SET_NUM; s++) begin
            ref_tree[s] = '0;
            for (int w = 0; w < ASSOCIATIVITY; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_bhr[s][w]   = '0;
                for (int h = 0; h < HIST_ENTRIES; h++) begin
                    ref_cnt[s][w][h] = 2'b11;
                end
            end
        end
    endtask

    function automatic int set_of(input addr_t pc);
        return int'(pc[3 +: SET_BITS]);
    endfunction

    function automatic int find_way(input int s, input logic [TAG_BITS-1:0] tag);
        for (int w = 0; w < ASSOCIATIVITY; w++) begin
            if (ref_valid[s][w] && ref_tag[s][w] == tag) begin
                return w;
            end
        end
        return -1;
    endfunction

    // walk from the root with 0 meaning left
    function automatic int ref_victim(input int s);
        int lo;
        int span;
        int node;
        lo   = 0;
        span = ASSOCIATIVITY;
        node = 1;
        while (span > 1) begin
            span = span / 2;
            if (ref_tree[s][node-1]) begin
                lo   = lo + span;
                node = 2 * node + 1;
            end else begin
                node = 2 * node;
            end
        end
        return lo;
    endfunction

    task automatic touch_tree(input int s, input int way);
        int lo;
        int span;
        int node;
        lo   = 0;
        span = ASSOCIATIVITY;
        node = 1;
        while (span > 1) begin
            span = span / 2;
            if (way >= lo + span) begin
                ref_tree[s][node-1] = 1'b0;   // way is right so point left
                lo   = lo + span;
                node = 2 * node + 1;
            end else begin
                ref_tree[s][node-1] = 1'b1;
                node = 2 * node;
            end
        end
    endtask

    task automatic apply_report(input addr_t pc, input addr_t dest, input logic taken,
                                input logic jump);
        int                 s;
        int                 w;
        logic [BH_BITS-1:0] h;
        s = set_of(pc);
        w = find_way(s, pc[31:2]);
        if (w >= 0) begin
            h = ref_bhr[s][w];
            if (taken && ref_cnt[s][w][h] != 2'b11) begin
                ref_cnt[s][w][h] = ref_cnt[s][w][h] + 2'b01;
            end else if (!taken && ref_cnt[s][w][h] != 2'b00) begin
                ref_cnt[s][w][h] = ref_cnt[s][w][h] - 2'b01;
            end
            ref_bhr[s][w] = {h[BH_BITS-2:0], taken};   // oldest outcome drops out
        end else begin
            w = ref_victim(s);
            ref_valid[s][w]  = 1'b1;
            ref_jump[s][w]   = jump;
            ref_tag[s][w]    = pc[31:2];
            ref_target[s][w] = dest;
            ref_bhr[s][w]    = '0;
            for (int i = 0; i < HIST_ENTRIES; i++) begin
                ref_cnt[s][w][i] = 2'b11;
            end
        end
    endtask

    task automatic expect_prediction(input addr_t pc, output logic slot, output logic taken,
                                     output addr_t next_pc);
        int    s;
        int    w0;
        int    w1;
        int    w;
        addr_t pc4;
        s     = set_of(pc);
        pc4   = pc + 32'd4;
        w0    = find_way(s, pc[31:2]);
        w1    = find_way(s, pc4[31:2]);
        w     = (w0 >= 0) ? w0 : w1;   // slot 0 first
        slot  = (w0 < 0) && (w1 >= 0);
        taken = 1'b0;
        next_pc = pc + FETCH_BYTES;
        if (w >= 0) begin
            taken = ref_jump[s][w] || ref_cnt[s][w][ref_bhr[s][w]][1];
            touch_tree(s, w);
            if (taken) begin
                next_pc = ref_target[s][w];
            end
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!bpu_ready) begin
            @(posedge clk);
            cycles++;
            if (cycles > READY_LIMIT) begin
                $display("bpu_ready did not rise after the table init sweep");
                stop_with_failure();
            end
        end
    endtask

    `include "bpu_tests.svh"

    initial begin
        int seed_ret;
        seed_ret    = $urandom(89866);
        rst         <= 1'b1;
        fetch_valid <= 1'b0;
        fetch_pc    <= '0;
        wb_cyc      <= 1'b0;
        wb_stb      <= 1'b0;
        wb_we       <= 1'b0;
        wb_adr      <= '0;
        wb_dat_w    <= '0;
        clear_ref_tables();
        repeat (7) @(posedge clk);
        @(negedge clk);
        check_bit("bpu_ready", bpu_ready, 1'b0);   // reset state
        check_bit("wb_ack", wb_ack, 1'b0);
        check_bit("pred_valid", pred_valid, 1'b0);
        @(posedge clk);
        rst <= 1'b0;
        wait_ready();
        test_cold_table();
        test_install();
        test_train();
        test_jump_priority();
        test_eviction();
        $display("** PASS **");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        stop_with_failure();
    end

endmodule

// ==== verilog.f ====
+incdir+tb
hdl/bpu_pkg.sv
hdl/lutram_dp.sv
hdl/plru_tree.sv
hdl/bht_update_wb.sv
hdl/bht.sv
hdl/next_pc_select.sv
hdl/bpu_top.sv
tb/bpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the bpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module bpu_tb -f verilog.f -o bpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/bpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
